//--- verilog/i2c_pkg.sv
// I2C master shared definitions
// byte and count types, bit engine command codes, bit phase constants

`default_nettype none

package i2c_pkg;

typedef logic [7:0] byte_t;
typedef logic [7:0] count_t;

// commands accepted by the bit engine
typedef enum logic [2:0] {
    cmd_start     = 3'd0,
    cmd_rep_start = 3'd1,
    cmd_write_bit = 3'd2,
    cmd_read_bit  = 3'd3,
    cmd_stop      = 3'd4
} bus_cmd_e;

// scl ticks per bit or bus condition
localparam int PHASE_COUNT = 4;

// msb goes out first
localparam int BYTE_MSB = 7;

// sda low on the ninth clock
localparam logic ACK_LEVEL = 1'b0;

endpackage

`default_nettype wire

//--- verilog/i2c_stream_slot.sv
// One-entry holding register for an input stream
// payload type is a parameter, ready is high while the slot is empty

`timescale 1ns/1ps
`default_nettype none

module i2c_stream_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           i_clk,
    input  wire           i_rst,
    input  wire           i_valid,
    input  wire payload_t i_payload,
    input  wire           i_take,
    output logic          o_ready,
    output logic          o_full,
    output payload_t      o_payload
);

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_full <= 1'b0;
    end else if (i_valid && o_ready) begin
        o_full <= 1'b1;
    end else if (i_take) begin
        o_full <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
        o_payload <= i_payload;
    end
end

assign o_ready = ~o_full;

// consumer only empties a slot it has seen full
a_take_when_full: assert property (@(posedge i_clk) disable iff (i_rst) i_take |-> o_full)
    else $error("slot emptied while already empty");

endmodule

`default_nettype wire

//--- verilog/i2c_bit_engine.sv
// I2C bit engine
// phase tick divider, four phase sequencer per bit or bus condition
// open-drain enables, scl stretch wait and sda sampling in phase 2

`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import i2c_pkg::*;
#(
    parameter int CLK_DIV  = 16,
    parameter int DIV_BITS = 24
) (
    input  wire           i_clk,
    input  wire           i_rst,
    input  wire           i_cmd_valid,
    input  wire bus_cmd_e i_cmd,
    input  wire           i_tx_bit,
    input  wire           i_scl_in,
    input  wire           i_sda_in,
    output logic          o_busy,
    output logic          o_done,
    output logic          o_rx_bit,
    output logic          o_sda_oe,
    output logic          o_scl_oe
);

localparam logic [1:0]          PH_LAST = 2'(PHASE_COUNT - 1);
localparam logic [DIV_BITS-1:0] DIV_END = DIV_BITS'(CLK_DIV);

logic [DIV_BITS-1:0] div_cnt;
logic                tick;
logic [1:0]          phase;
bus_cmd_e            cmd_q;
logic                tx_q;
logic [1:0]          scl_sync;
logic [1:0]          sda_sync;
logic                scl_in;
logic                sda_in;

// divider restarts per command so every phase is CLK_DIV+1 cycles
always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        div_cnt <= '0;
    end else if (!o_busy || tick) begin
        div_cnt <= '0;
    end else begin
        div_cnt <= div_cnt + 1'b1;
    end
end

assign tick = o_busy && (div_cnt == DIV_END);

// bus lines come from outside the clock domain
always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        scl_sync <= 2'b11;
        sda_sync <= 2'b11;
    end else begin
        scl_sync <= {scl_sync[0], i_scl_in};
        sda_sync <= {sda_sync[0], i_sda_in};
    end
end

assign scl_in = scl_sync[1];
assign sda_in = sda_sync[1];

always_ff @(posedge i_clk) begin
    if (i_cmd_valid) begin
        cmd_q <= i_cmd;
        tx_q  <= i_tx_bit;
    end
    if (tick && phase == 2'd2 && scl_in) begin
        o_rx_bit <= sda_in;
    end
end

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_busy   <= 1'b0;
        o_done   <= 1'b0;
        phase    <= '0;
        o_sda_oe <= 1'b0;
        o_scl_oe <= 1'b0;
    end else begin
        o_done <= 1'b0;
        if (i_cmd_valid) begin
            o_busy <= 1'b1;
            phase  <= '0;
        end else if (tick) begin
            if (phase == PH_LAST) begin
                // stop releases sda with scl high, the rest park scl low
                if (cmd_q == cmd_stop) begin
                    o_sda_oe <= 1'b0;
                end else begin
                    o_scl_oe <= 1'b1;
                end
                o_busy <= 1'b0;
                o_done <= 1'b1;
                phase  <= '0;
            end else if (phase == 2'd2) begin
                // target may still be stretching
                if (scl_in) begin
                    if (cmd_q == cmd_rep_start) begin
                        o_sda_oe <= 1'b1;
                    end
                    phase <= phase + 1'b1;
                end
            end else if (phase == 2'd1) begin
                if (cmd_q == cmd_start) begin
                    o_sda_oe <= 1'b1;
                end else begin
                    o_scl_oe <= 1'b0;
                end
                phase <= phase + 1'b1;
            end else begin
                case (cmd_q)
                    cmd_write_bit: o_sda_oe <= ~tx_q;
                    cmd_stop:      o_sda_oe <= 1'b1;
                    default:       o_sda_oe <= 1'b0;
                endcase
                phase <= phase + 1'b1;
            end
        end
    end
end

a_cmd_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cmd_valid |-> !o_busy)
    else $error("command issued while bit engine busy");

endmodule

`default_nettype wire

//--- verilog/i2c_txn_ctrl.sv
// I2C transaction controller
// start, address and data bytes, ack check, repeated start,
// read bytes with ack or nak, stop; one bit engine command at a time

`timescale 1ns/1ps
`default_nettype none

module i2c_txn_ctrl
    import i2c_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst,
    input  wire           i_start,
    input  wire           i_addr_full,
    input  wire byte_t    i_addr,
    input  wire           i_data_full,
    input  wire byte_t    i_data,
    input  wire           i_count_full,
    input  wire count_t   i_count,
    input  wire           i_eng_busy,
    input  wire           i_eng_done,
    input  wire           i_eng_rx_bit,
    input  wire           i_out_held,
    output logic          o_take_addr,
    output logic          o_take_data,
    output logic          o_take_count,
    output logic          o_cmd_valid,
    output bus_cmd_e      o_cmd,
    output logic          o_tx_bit,
    output logic          o_rx_strobe,
    output logic          o_rx_bit,
    output logic          o_rx_last,
    output logic          o_nak,
    output logic          o_busy
);

typedef enum logic [3:0] {
    S_IDLE, S_START, S_SEND, S_ACK_CHECK, S_WAIT_COUNT,
    S_REP_START, S_READ, S_GEN_ACK, S_STOP
} state_e;

// which byte S_SEND is shifting out
typedef enum logic [1:0] {K_ADDR_W, K_DATA, K_ADDR_R} kind_e;

state_e     state;
kind_e      kind;
logic [2:0] bit_cnt;
count_t     remaining;
logic       cmd_sent;
byte_t      addr_q;
byte_t      data_q;
logic       last_bit;
logic       last_byte;
logic       acked;
logic       wants_data;
logic       cmd_needed;
logic       wr_bit;

assign last_bit   = (bit_cnt == '0);
assign last_byte  = (remaining == count_t'(1));
assign acked      = (i_eng_rx_bit == ACK_LEVEL);
// address ack always needs a byte, a data ack only in a write
assign wants_data = (kind == K_ADDR_W) || (kind == K_DATA && !addr_q[0]);

assign o_take_addr  = (state == S_IDLE) && i_start && i_addr_full;
assign o_take_data  = (state == S_ACK_CHECK) && i_eng_done && acked && wants_data
                    && i_data_full;
assign o_take_count = (state == S_WAIT_COUNT) && i_count_full;

assign o_rx_strobe = (state == S_READ) && i_eng_done;
assign o_rx_bit    = i_eng_rx_bit;
assign o_rx_last   = last_bit;

always_comb begin
    case (kind)
        K_DATA:   wr_bit = data_q[bit_cnt];
        K_ADDR_R: wr_bit = last_bit ? 1'b1 : addr_q[bit_cnt];
        default:  wr_bit = last_bit ? 1'b0 : addr_q[bit_cnt];
    endcase
end

always_comb begin
    cmd_needed = 1'b1;
    o_cmd      = cmd_write_bit;
    o_tx_bit   = 1'b1;
    case (state)
        S_START:              o_cmd = cmd_start;
        S_SEND:               o_tx_bit = wr_bit;
        S_ACK_CHECK, S_READ:  o_cmd = cmd_read_bit;
        S_REP_START:          o_cmd = cmd_rep_start;
        S_STOP:               o_cmd = cmd_stop;
        S_GEN_ACK: begin
            // a held byte keeps scl low until it is taken
            cmd_needed = !i_out_held;
            o_tx_bit   = last_byte ? ~ACK_LEVEL : ACK_LEVEL;
        end
        default:              cmd_needed = 1'b0;
    endcase
end

assign o_cmd_valid = cmd_needed && !cmd_sent && !i_eng_busy;

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        state     <= S_IDLE;
        kind      <= K_ADDR_W;
        bit_cnt   <= '0;
        remaining <= '0;
        cmd_sent  <= 1'b0;
        o_busy    <= 1'b0;
        o_nak     <= 1'b0;
    end else begin
        if (i_eng_done) begin
            cmd_sent <= 1'b0;
        end else if (o_cmd_valid) begin
            cmd_sent <= 1'b1;
        end
        case (state)
            S_IDLE: begin
                if (o_take_addr) begin
                    o_busy <= 1'b1;
                    o_nak  <= 1'b0;
                    state  <= S_START;
                end
            end
            S_WAIT_COUNT: begin
                if (i_count_full) begin
                    remaining <= i_count;
                    state     <= S_REP_START;
                end
            end
            S_START, S_REP_START: begin
                if (i_eng_done) begin
                    kind    <= (state == S_START) ? K_ADDR_W : K_ADDR_R;
                    bit_cnt <= 3'(BYTE_MSB);
                    state   <= S_SEND;
                end
            end
            S_SEND: begin
                if (i_eng_done) begin
                    if (last_bit) begin
                        state <= S_ACK_CHECK;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
            end
            S_ACK_CHECK: begin
                if (i_eng_done) begin
                    bit_cnt <= 3'(BYTE_MSB);
                    if (!acked) begin
                        o_nak <= 1'b1;
                        state <= S_STOP;
                    end else if (kind == K_ADDR_R) begin
                        state <= S_READ;
                    end else if (!wants_data) begin
                        state <= S_WAIT_COUNT;
                    end else if (i_data_full) begin
                        kind  <= K_DATA;
                        state <= S_SEND;
                    end else begin
                        state <= S_STOP;
                    end
                end
            end
            S_READ: begin
                if (i_eng_done) begin
                    if (last_bit) begin
                        state <= S_GEN_ACK;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
            end
            S_GEN_ACK: begin
                if (i_eng_done) begin
                    remaining <= remaining - 1'b1;
                    bit_cnt   <= 3'(BYTE_MSB);
                    if (last_byte) begin
                        state <= S_STOP;
                    end else begin
                        state <= S_READ;
                    end
                end
            end
            S_STOP: begin
                if (i_eng_done) begin
                    o_busy <= 1'b0;
                    state  <= S_IDLE;
                end
            end
            default: state <= S_IDLE;
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (o_take_addr) begin
        addr_q <= i_addr;
    end
    if (o_take_data) begin
        data_q <= i_data;
    end
end

a_count_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
    o_take_count |-> (i_count != '0))
    else $error("register read with a byte count of zero");

endmodule

`default_nettype wire

//--- verilog/i2c_read_out.sv
// Read data output
// msb-first byte assembly and the held output stream register

`timescale 1ns/1ps
`default_nettype none

module i2c_read_out
    import i2c_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_rst,
    input  wire   i_rx_strobe,
    input  wire   i_rx_bit,
    input  wire   i_rx_last,
    input  wire   i_data_ready,
    output byte_t o_data_bits,
    output logic  o_data_valid,
    output logic  o_held
);

byte_t shift_q;

always_ff @(posedge i_clk) begin
    if (i_rx_strobe) begin
        shift_q <= {shift_q[BYTE_MSB-1:0], i_rx_bit};
        if (i_rx_last) begin
            o_data_bits <= {shift_q[BYTE_MSB-1:0], i_rx_bit};
        end
    end
end

always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
        o_data_valid <= 1'b0;
    end else if (i_rx_strobe && i_rx_last) begin
        o_data_valid <= 1'b1;
    end else if (i_data_ready) begin
        o_data_valid <= 1'b0;
    end
end

// still occupied after this clock
assign o_held = o_data_valid && !i_data_ready;

a_no_overrun: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rx_strobe && i_rx_last) |-> !o_data_valid)
    else $error("read byte completed while previous byte still held");

endmodule

`default_nettype wire

//--- verilog/i2c_master.sv
// I2C master top level
// input stream slots, transaction controller, bit engine, read output

`timescale 1ns/1ps
`default_nettype none

module i2c_master
    import i2c_pkg::*;
#(
    parameter int CLK_DIV  = 16,
    parameter int DIV_BITS = 24
) (
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire         i_start,
    input  wire byte_t  i_addr_bits,
    input  wire         i_addr_valid,
    output logic        o_addr_ready,
    input  wire count_t i_nbytes_bits,
    input  wire         i_nbytes_valid,
    output logic        o_nbytes_ready,
    input  wire byte_t  i_data_bits,
    input  wire         i_data_valid,
    output logic        o_data_ready,
    output byte_t       o_data_bits,
    output logic        o_data_valid,
    input  wire         i_data_ready,
    input  wire         i_sda_in,
    input  wire         i_scl_in,
    output logic        o_sda_oe,
    output logic        o_scl_oe,
    output logic        o_nak,
    output logic        o_busy
);

logic     addr_full;
byte_t    addr_q;
logic     data_full;
byte_t    data_q;
logic     count_full;
count_t   count_q;
logic     take_addr;
logic     take_data;
logic     take_count;
logic     cmd_valid;
bus_cmd_e cmd;
logic     tx_bit;
logic     eng_busy;
logic     eng_done;
logic     eng_rx_bit;
logic     rx_strobe;
logic     rx_bit;
logic     rx_last;
logic     out_held;

i2c_stream_slot #(.payload_t(byte_t)) u_addr_slot (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_addr_valid),
    .i_payload (i_addr_bits),
    .i_take    (take_addr),
    .o_ready   (o_addr_ready),
    .o_full    (addr_full),
    .o_payload (addr_q)
);

i2c_stream_slot #(.payload_t(byte_t)) u_data_slot (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_data_valid),
    .i_payload (i_data_bits),
    .i_take    (take_data),
    .o_ready   (o_data_ready),
    .o_full    (data_full),
    .o_payload (data_q)
);

i2c_stream_slot #(.payload_t(count_t)) u_count_slot (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_nbytes_valid),
    .i_payload (i_nbytes_bits),
    .i_take    (take_count),
    .o_ready   (o_nbytes_ready),
    .o_full    (count_full),
    .o_payload (count_q)
);

i2c_txn_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (i_start),
    .i_addr_full  (addr_full),
    .i_addr       (addr_q),
    .i_data_full  (data_full),
    .i_data       (data_q),
    .i_count_full (count_full),
    .i_count      (count_q),
    .i_eng_busy   (eng_busy),
    .i_eng_done   (eng_done),
    .i_eng_rx_bit (eng_rx_bit),
    .i_out_held   (out_held),
    .o_take_addr  (take_addr),
    .o_take_data  (take_data),
    .o_take_count (take_count),
    .o_cmd_valid  (cmd_valid),
    .o_cmd        (cmd),
    .o_tx_bit     (tx_bit),
    .o_rx_strobe  (rx_strobe),
    .o_rx_bit     (rx_bit),
    .o_rx_last    (rx_last),
    .o_nak        (o_nak),
    .o_busy       (o_busy)
);

i2c_bit_engine #(
    .CLK_DIV  (CLK_DIV),
    .DIV_BITS (DIV_BITS)
) u_engine (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd),
    .i_tx_bit    (tx_bit),
    .i_scl_in    (i_scl_in),
    .i_sda_in    (i_sda_in),
    .o_busy      (eng_busy),
    .o_done      (eng_done),
    .o_rx_bit    (eng_rx_bit),
    .o_sda_oe    (o_sda_oe),
    .o_scl_oe    (o_scl_oe)
);

i2c_read_out u_read_out (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rx_strobe  (rx_strobe),
    .i_rx_bit     (rx_bit),
    .i_rx_last    (rx_last),
    .i_data_ready (i_data_ready),
    .o_data_bits  (o_data_bits),
    .o_data_valid (o_data_valid),
    .o_held       (out_held)
);

endmodule

`default_nettype wire

//--- tests/i2c_target_model.sv
// Behavioral I2C target
// wired-AND releases for both lines, scripted ack mask and read bytes,
// scl stretch after every falling edge, log of bytes, acks, start and stop

`timescale 1ns/1ps
`default_nettype none

module i2c_target_model (
    input  wire        i_clk,
    input  wire        i_scl,
    input  wire        i_sda,
    input  wire [7:0]  i_ack_mask,
    input  wire [15:0] i_stretch,
    input  wire [31:0] i_rd_data,
    output logic       o_scl_rel,
    output logic       o_sda_rel
);

localparam int MODE_IDLE = 0;
localparam int MODE_RX   = 1;
localparam int MODE_TX   = 2;

// 0x100 start, 0x200 stop, 0x300 master ack, 0x301 master nak, else a byte
logic [9:0] log_mem [0:127];
int         log_cnt = 0;
int         mode = MODE_IDLE;
int         bit_cnt = 0;
int         wr_idx = 0;
int         rd_idx = 0;
logic [7:0] shift = 8'h00;
logic       ack_phase = 1'b0;
logic       read_next = 1'b0;
logic       first_byte = 1'b0;
logic       ack = 1'b0;
logic       prev_scl = 1'b1;
logic       prev_sda = 1'b1;

initial begin
    o_scl_rel = 1'b1;
    o_sda_rel = 1'b1;
end

task automatic add_log(input logic [9:0] entry);
    log_mem[log_cnt] = entry;
    log_cnt++;
endtask

// pos 0 is the msb of read byte idx
function automatic logic rd_bit(input int idx, input int pos);
    return i_rd_data[31 - 8 * idx - pos];
endfunction

always @(i_scl or i_sda) begin
    if (prev_scl && i_scl && prev_sda && !i_sda) begin
        add_log(10'h100);
        mode       = MODE_RX;
        bit_cnt    = 0;
        ack_phase  = 1'b0;
        read_next  = 1'b0;
        first_byte = 1'b1;
        o_sda_rel  = 1'b1;
    end else if (prev_scl && i_scl && !prev_sda && i_sda) begin
        add_log(10'h200);
        mode      = MODE_IDLE;
        wr_idx    = 0;
        rd_idx    = 0;
        o_sda_rel = 1'b1;
    end else if (!prev_scl && i_scl) begin
        if (mode == MODE_RX && !ack_phase && bit_cnt < 8) begin
            shift = {shift[6:0], i_sda};
            bit_cnt++;
        end else if (mode == MODE_TX) begin
            if (bit_cnt < 8) begin
                bit_cnt++;
            end else begin
                // ninth clock carries the master's ack
                add_log(i_sda ? 10'h301 : 10'h300);
                if (i_sda) begin
                    mode = MODE_IDLE;
                end else begin
                    rd_idx++;
                    bit_cnt = 9;
                end
            end
        end
    end else if (prev_scl && !i_scl) begin
        #1;
        if (mode == MODE_RX) begin
            if (ack_phase) begin
                ack_phase = 1'b0;
                bit_cnt   = 0;
                o_sda_rel = 1'b1;
                if (read_next) begin
                    mode      = MODE_TX;
                    read_next = 1'b0;
                    o_sda_rel = rd_bit(rd_idx, 0);
                end
            end else if (bit_cnt == 8) begin
                add_log({2'b00, shift});
                ack        = i_ack_mask[wr_idx[2:0]];
                wr_idx++;
                o_sda_rel  = !ack;
                ack_phase  = 1'b1;
                read_next  = first_byte && shift[0] && ack;
                first_byte = 1'b0;
            end
        end else if (mode == MODE_TX) begin
            if (bit_cnt == 9) begin
                bit_cnt = 0;
            end
            if (bit_cnt < 8) begin
                o_sda_rel = rd_bit(rd_idx, bit_cnt);
            end else begin
                o_sda_rel = 1'b1;
            end
        end
        if (i_stretch != 16'd0) begin
            o_scl_rel = 1'b0;
            repeat (i_stretch) @(posedge i_clk);
            #2;
            o_scl_rel = 1'b1;
        end
    end
    prev_scl = i_scl;
    prev_sda = i_sda;
end

endmodule

`default_nettype wire

//--- tests/tb_i2c_master.sv
// I2C master testbench
// vectors from a data file, stream driving, read back-pressure,
// bus log compare against the transfer rules, cycle limit

`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

localparam int CLK_DIV = 3;
localparam int NUM_VEC = 7;
localparam int NUM_COL = 14;

logic        i_clk;
logic        i_rst;
logic        i_start;
byte_t       addr_bits;
logic        addr_valid;
logic        addr_ready;
count_t      nbytes_bits;
logic        nbytes_valid;
logic        nbytes_ready;
byte_t       wdata_bits;
logic        wdata_valid;
logic        wdata_ready;
byte_t       rdata_bits;
logic        rdata_valid;
logic        rdata_ready;
logic        sda_oe;
logic        scl_oe;
logic        nak;
logic        busy;
logic        tgt_scl_rel;
logic        tgt_sda_rel;
logic [7:0]  ack_mask;
logic [15:0] stretch;
logic [31:0] rd_data;
wire         scl;
wire         sda;

logic [15:0] vec_mem [0:NUM_VEC*NUM_COL-1];
logic [9:0]  exp_log [$];
byte_t       exp_rd [$];
int          cycle_cnt = 0;
int          cycle_limit = 0;

// pull-up level wired with both open-drain sides
assign scl = 1'b1 & ~scl_oe & tgt_scl_rel;
assign sda = 1'b1 & ~sda_oe & tgt_sda_rel;

i2c_master #(.CLK_DIV(CLK_DIV)) u_dut (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start),
    .i_addr_bits(addr_bits), .i_addr_valid(addr_valid), .o_addr_ready(addr_ready),
    .i_nbytes_bits(nbytes_bits), .i_nbytes_valid(nbytes_valid),
    .o_nbytes_ready(nbytes_ready),
    .i_data_bits(wdata_bits), .i_data_valid(wdata_valid), .o_data_ready(wdata_ready),
    .o_data_bits(rdata_bits), .o_data_valid(rdata_valid), .i_data_ready(rdata_ready),
    .i_sda_in(sda), .i_scl_in(scl),
    .o_sda_oe(sda_oe), .o_scl_oe(scl_oe), .o_nak(nak), .o_busy(busy)
);

i2c_target_model u_target (
    .i_clk(i_clk), .i_scl(scl), .i_sda(sda), .i_ack_mask(ack_mask),
    .i_stretch(stretch), .i_rd_data(rd_data),
    .o_scl_rel(tgt_scl_rel), .o_sda_rel(tgt_sda_rel)
);

initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
end

always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
        $display("timeout: the vectors did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $fatal(1, "cycle limit reached");
    end
end

task automatic check_value(input string name, input int actual, input int expected);
    if (actual !== expected) begin
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual,
                 expected);
        $display("Checks failed");
        $fatal(1, "value mismatch");
    end
endtask

function automatic int col(input int v, input int c);
    return int'(vec_mem[v * NUM_COL + c]);
endfunction

// inputs change a little after the rising edge
task automatic next_cycle();
    @(posedge i_clk);
    #2;
endtask

task automatic apply_reset();
    i_rst        = 1'b1;
    i_start      = 1'b0;
    addr_valid   = 1'b0;
    nbytes_valid = 1'b0;
    wdata_valid  = 1'b0;
    rdata_ready  = 1'b0;
    repeat (3) next_cycle();
    i_rst = 1'b0;
    check_value("o_sda_oe", sda_oe, 0);
    check_value("o_scl_oe", scl_oe, 0);
    check_value("o_data_valid", rdata_valid, 0);
    check_value("o_nak", nak, 0);
    check_value("o_busy", busy, 0);
    check_value("o_addr_ready", addr_ready, 1);
    check_value("o_nbytes_ready", nbytes_ready, 1);
    check_value("o_data_ready", wdata_ready, 1);
endtask

task automatic build_expected(input int v, output int exp_nak);
    int addr;
    int ndata;
    int count;
    int mask;
    int i;
    addr  = col(v, 0);
    ndata = col(v, 1);
    count = col(v, 6);
    mask  = col(v, 7);
    exp_log.delete();
    exp_rd.delete();
    exp_nak = 0;
    exp_log.push_back(10'h100);
    exp_log.push_back(10'(addr & 'hfe));
    if (!mask[0]) begin
        exp_nak = 1;
    end else if (!addr[0]) begin
        for (i = 0; i < ndata; i++) begin
            exp_log.push_back(10'(col(v, 2 + i)));
            if (!mask[i + 1]) begin
                exp_nak = 1;
                break;
            end
        end
    end else begin
        exp_log.push_back(10'(col(v, 2)));
        if (!mask[1]) begin
            exp_nak = 1;
        end else begin
            exp_log.push_back(10'h100);
            exp_log.push_back(10'(addr | 1));
            if (!mask[2]) begin
                exp_nak = 1;
            end else begin
                // last read byte gets the nak
                for (i = 0; i < count; i++) begin
                    exp_log.push_back((i == count - 1) ? 10'h301 : 10'h300);
                    exp_rd.push_back(byte_t'(col(v, 9 + i)));
                end
            end
        end
    end
    exp_log.push_back(10'h200);
endtask

task automatic run_vector(input int v);
    int    ndata;
    int    hold;
    int    pushed;
    int    hold_left;
    int    log_start;
    int    exp_nak;
    int    i;
    logic  addr_nak;
    logic  seen_busy;
    logic  done;
    byte_t held;
    ndata    = col(v, 1);
    hold     = col(v, 13);
    ack_mask = 8'(col(v, 7));
    stretch  = 16'(col(v, 8));
    rd_data  = {8'(col(v, 9)), 8'(col(v, 10)), 8'(col(v, 11)), 8'(col(v, 12))};
    addr_nak = !ack_mask[0];
    apply_reset();
    build_expected(v, exp_nak);
    log_start = u_target.log_cnt;
    addr_bits  = byte_t'(col(v, 0));
    addr_valid = 1'b1;
    pushed     = 0;
    if (ndata > 0) begin
        wdata_bits  = byte_t'(col(v, 2));
        wdata_valid = 1'b1;
        pushed      = 1;
    end
    if (col(v, 0) % 2 == 1) begin
        nbytes_bits  = count_t'(col(v, 6));
        nbytes_valid = 1'b1;
    end
    next_cycle();
    addr_valid   = 1'b0;
    wdata_valid  = 1'b0;
    nbytes_valid = 1'b0;
    i_start      = 1'b1;
    next_cycle();
    i_start   = 1'b0;
    seen_busy = 1'b0;
    done      = 1'b0;
    hold_left = hold;
    held      = 8'h00;
    while (!done) begin
        if (busy) begin
            seen_busy = 1'b1;
        end else if (seen_busy) begin
            done = 1'b1;
        end
        if (wdata_ready && pushed < ndata) begin
            wdata_bits  = byte_t'(col(v, 2 + pushed));
            wdata_valid = 1'b1;
            pushed++;
        end else begin
            wdata_valid = 1'b0;
        end
        if (rdata_valid) begin
            if (hold_left > 0) begin
                if (hold_left == hold) begin
                    held = rdata_bits;
                end
                check_value("o_data_bits during hold", rdata_bits, held);
                check_value("o_scl_oe during hold", scl_oe, 1);
                hold_left--;
                rdata_ready = 1'b0;
            end else begin
                check_value("read bytes left", exp_rd.size() > 0, 1);
                check_value("o_data_bits", rdata_bits, exp_rd.pop_front());
                rdata_ready = 1'b1;
            end
        end else begin
            if (hold_left > 0 && hold_left < hold) begin
                check_value("o_data_valid during hold", rdata_valid, 1);
            end
            rdata_ready = 1'b0;
            hold_left   = hold;
        end
        if (addr_nak) begin
            check_value("o_data_ready", wdata_ready, 0);
        end
        if (!done) begin
            next_cycle();
        end
    end
    check_value("o_nak", nak, exp_nak);
    check_value("read bytes missing", exp_rd.size(), 0);
    check_value("o_sda_oe after stop", sda_oe, 0);
    check_value("o_scl_oe after stop", scl_oe, 0);
    check_value("bus log length", u_target.log_cnt - log_start, exp_log.size());
    for (i = 0; i < exp_log.size(); i++) begin
        check_value("bus log entry", u_target.log_mem[log_start + i], exp_log[i]);
    end
endtask

initial begin
    int v;
    int bits;
    i_rst        = 1'b1;
    i_start      = 1'b0;
    addr_bits    = 8'h00;
    addr_valid   = 1'b0;
    nbytes_bits  = 8'h00;
    nbytes_valid = 1'b0;
    wdata_bits   = 8'h00;
    wdata_valid  = 1'b0;
    rdata_ready  = 1'b0;
    ack_mask     = 8'h00;
    stretch      = 16'h0000;
    rd_data      = 32'h0;
    $readmemh("tests/i2c_input.txt", vec_mem);
    for (v = 0; v < NUM_VEC; v++) begin
        bits = 3 + 9 * (2 + col(v, 1) + col(v, 6));
        cycle_limit += 2 * (bits * PHASE_COUNT * (CLK_DIV + 1) + bits * col(v, 8)
                       + col(v, 6) * col(v, 13) + 10);
    end
    for (v = 0; v < NUM_VEC; v++) begin
        run_vector(v);
    end
    $display("All checks passed");
    $finish;
end

endmodule

`default_nettype wire

//--- files.f
verilog/i2c_pkg.sv
verilog/i2c_stream_slot.sv
verilog/i2c_bit_engine.sv
verilog/i2c_txn_ctrl.sv
verilog/i2c_read_out.sv
verilog/i2c_master.sv
tests/i2c_target_model.sv
tests/tb_i2c_master.sv

//--- Makefile
# Verilator build and run of the I2C master testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -sv -Wno-fatal -f files.f \
		--top-module tb_i2c_master -Mdir obj_dir -o sim_i2c_master
	./obj_dir/sim_i2c_master

clean:
	rm -rf obj_dir

//--- tests/i2c_input.txt
// addr ndata d0 d1 d2 d3 count ackmask stretch r0 r1 r2 r3 hold
// ackmask bit n acks written byte n, stretch and hold in clock cycles
a0 03 11 22 33 00 00 ff 00 00 00 00 00 0000
b4 01 55 00 00 00 00 00 00 00 00 00 00 0000
a1 01 10 00 00 00 03 ff 00 5a c3 0f 00 0000
a1 01 20 00 00 00 02 ff 00 96 69 00 00 012c
a0 03 11 22 33 00 00 ff 14 00 00 00 00 0000
40 03 c1 d2 e3 00 00 03 00 00 00 00 00 0000
a1 01 30 00 00 00 02 ff 0c e7 18 00 00 0005
